//--- common/zip_dbg_pkg.sv
// Debug controller shared definitions
// Bus widths, run-control bit positions and the packed types that pass
// between the AXI-lite stages, run control and the CPU debug port
package zip_dbg_pkg;

	// Debug bus geometry
	localparam int DBG_ADDR_W = 8;
	localparam int DBG_DATA_W = 32;
	// Byte offset bits, dropped before decode
	localparam int DBG_LSB = 2;

	// Word address, bit 5 picks command vs register
	typedef logic [DBG_ADDR_W-DBG_LSB-1:0] dbg_waddr_t;
	typedef logic [4:0] dbg_reg_t;
	typedef logic [DBG_DATA_W-1:0] dbg_word_t;

	// Command and status bit positions
	localparam int RESET_BIT = 6;
	localparam int STEP_BIT = 8;
	localparam int HALT_BIT = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Command word as written by the debugger
	typedef struct packed {
		logic [19:0] rsvd;
		logic clear_cache;
		logic halt;
		logic spare_9;
		logic step;
		logic spare_7;
		logic reset;
		logic [5:0] low;
	} dbg_cmd_t;

	// Same write word, seen as command or as register data
	typedef union packed {
		dbg_cmd_t cmd;
		dbg_word_t word;
	} dbg_wdata_u;

	// Register write towards the CPU
	typedef struct packed {
		logic we;
		dbg_reg_t wreg;
		dbg_word_t data;
	} dbg_wr_t;

	// Accepted write, as seen by run control
	typedef struct packed {
		logic valid;
		logic [3:0] strb;
		logic fire;
	} dbg_cmd_req_t;

	// State reported back by the CPU
	typedef struct packed {
		logic stall;
		logic brk;
		logic [2:0] cc;
	} cpu_dbg_t;

endpackage

//--- design/dbg_skid.sv
// Skid buffer for one AXI-lite channel
// Non-registered path, one spare entry catches the word when the
// downstream stage stalls
`timescale 1ns/1ps

module dbg_skid #(
	parameter int DW = 8
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	input  logic          i_valid,
	output logic          o_ready,
	input  logic [DW-1:0] i_data,
	output logic          o_valid,
	input  logic          i_ready,
	output logic [DW-1:0] o_data
);

	// Spare entry is full
	logic r_valid;
	logic [DW-1:0] r_data;

	// Fill when upstream hands over a word the stage can't take
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Only capture while empty, zero when idle to keep the bus quiet
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_valid ? i_data : '0;
	end

	// Accept whenever the spare slot is free
	assign o_ready = !r_valid;

	// Held word has priority over the live one
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

//--- debug_port/dbg_write_stage.sv
// Debug write stage
// Joins the AW and W words, sends register writes to the CPU,
// hands command writes to run control and returns B
`timescale 1ns/1ps

module dbg_write_stage import zip_dbg_pkg::*; (
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,
	input  logic        i_aw_valid,
	input  dbg_waddr_t  i_aw_addr,
	input  logic        i_w_valid,
	input  dbg_wdata_u  i_w_data,
	input  logic [3:0]  i_w_strb,
	output logic        o_wr_ready,
	input  logic        i_cpu_stall,
	output dbg_wr_t     o_dbg_wr,
	output dbg_cmd_req_t o_cmd,
	output dbg_wdata_u  o_cmd_word,
	output logic        o_reg_unhalt,
	output logic        S_DBG_BVALID,
	input  logic        i_bready,
	output logic [1:0]  S_DBG_BRESP
);

	logic wr_ready, wr_stall, is_cmd, has_strb, reg_wr;
	logic wr_we;
	dbg_reg_t wr_reg;
	dbg_word_t wr_data;

	//////////////////////////////
	// Accept
	//////////////////////////////

	// Upper word address bit selects the command port
	assign is_cmd = i_aw_addr[5];
	assign has_strb = |i_w_strb;
	// CPU busy with the previous register write
	assign wr_stall = wr_we && i_cpu_stall;

	// Both halves present, B slot free, CPU able to take a register write
	assign wr_ready = i_aw_valid && i_w_valid
			&& (!S_DBG_BVALID || i_bready)
			&& (is_cmd || !has_strb || !wr_stall);
	assign o_wr_ready = wr_ready;

	// Real register write on this cycle
	assign reg_wr = wr_ready && has_strb && !is_cmd;
	assign o_reg_unhalt = reg_wr;

	// Commands go straight through, run control registers them
	assign o_cmd = '{valid: wr_ready, strb: i_w_strb, fire: wr_ready && is_cmd};
	assign o_cmd_word = (wr_ready && is_cmd) ? i_w_data : '0;

	//////////////////////////////
	// Register write port
	//////////////////////////////

	// Pulse held through a CPU stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_we <= 1'b0;
		else if (!wr_stall)
			wr_we <= reg_wr;
	end

	// Index and data, zero when nothing is written
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!wr_stall)
		begin
			wr_reg <= reg_wr ? i_aw_addr[4:0] : '0;
			wr_data <= wr_ready ? i_w_data.word : '0;
		end
	end

	assign o_dbg_wr = '{we: wr_we, wreg: wr_reg, data: wr_data};

	// Write response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_DBG_BVALID || !S_AXI_ARESETN)
			S_DBG_BVALID <= S_AXI_ARESETN && wr_ready;
		else if (i_bready)
			S_DBG_BVALID <= wr_ready;
	end

	// Always OKAY
	assign S_DBG_BRESP = 2'b00;

endmodule

//--- debug_port/dbg_read_stage.sv
// Debug read stage
// Status reads answer in one cycle, CPU register reads take a second
// cycle while the CPU looks up the register
`timescale 1ns/1ps

module dbg_read_stage import zip_dbg_pkg::*; (
	input  logic       S_AXI_ACLK,
	input  logic       S_AXI_ARESETN,
	input  logic       i_ar_valid,
	input  dbg_waddr_t i_ar_addr,
	output logic       o_ar_ready,
	output dbg_reg_t   o_dbg_rreg,
	input  dbg_word_t  i_dbg_rdata,
	input  dbg_word_t  i_status,
	output logic       S_DBG_RVALID,
	input  logic       i_rready,
	output dbg_word_t  S_DBG_RDATA,
	output logic [1:0] S_DBG_RRESP
);

	logic rd_ready, rd_pending, r_slot_free, is_reg;
	dbg_reg_t rd_reg;

	// Upper bit set reads a CPU register
	assign is_reg = i_ar_addr[5];
	assign r_slot_free = !S_DBG_RVALID || i_rready;

	// Nothing new while a register lookup is in flight
	assign rd_ready = i_ar_valid && !rd_pending && r_slot_free;
	assign o_ar_ready = rd_ready;

	//////////////////////////////
	// Register lookup
	//////////////////////////////

	// Middle cycle of a register read
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_pending <= 1'b0;
		else
			rd_pending <= rd_ready && is_reg;
	end

	// Index held for the CPU during the lookup
	always_ff @(posedge S_AXI_ACLK)
	begin
		rd_reg <= (rd_ready && is_reg) ? i_ar_addr[4:0] : '0;
	end
	assign o_dbg_rreg = rd_reg;

	//////////////////////////////
	// Read response
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_RVALID <= 1'b0;
		else if (r_slot_free)
			S_DBG_RVALID <= (rd_ready && !is_reg) || rd_pending;
	end

	// Register data wins, then status, else zero
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (r_slot_free)
		begin
			if (rd_pending)
				S_DBG_RDATA <= i_dbg_rdata;
			else if (rd_ready && !is_reg)
				S_DBG_RDATA <= i_status;
			else
				S_DBG_RDATA <= '0;
		end
	end

	assign S_DBG_RRESP = 2'b00;

endmodule

//--- design/cpu_run_ctrl.sv
// CPU run control
// Power-on reset hold, the reset, halt, step and clear-cache requests
// to the CPU, and the status word seen by the debugger
`timescale 1ns/1ps

module cpu_run_ctrl import zip_dbg_pkg::*; #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input  logic         S_AXI_ACLK,
	input  logic         S_AXI_ARESETN,
	input  logic         i_cpu_reset,
	input  logic         i_interrupt,
	input  dbg_cmd_req_t i_cmd,
	input  dbg_wdata_u   i_cmd_word,
	input  logic         i_reg_unhalt,
	input  cpu_dbg_t     i_cpu,
	input  logic         i_wr_pending,
	output logic         o_cpu_reset,
	output logic         o_cpu_halt,
	output logic         o_cpu_clear_cache,
	output dbg_word_t    o_status
);

	localparam int CNT_W = (RESET_DURATION > 1) ? $clog2(RESET_DURATION + 1) : 1;

	logic [CNT_W-1:0] reset_cnt;
	logic reset_hold, cmd_reset, cmd_halt, cmd_step, cmd_clear_cache;
	logic cmd_b1, wr_stall;

	// Command write touching the run-control byte
	assign cmd_b1 = i_cmd.fire && i_cmd.strb[1];
	assign wr_stall = i_wr_pending && i_cpu.stall;

	//////////////////////////////
	// Reset hold
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
		begin
			reset_cnt <= CNT_W'(RESET_DURATION);
			reset_hold <= 1'b1;
		end
		else
		begin
			if (reset_cnt > 0)
				reset_cnt <= reset_cnt - 1'b1;
			reset_hold <= (reset_cnt > 1);
		end
	end

	// Break resets the CPU unless it is meant to halt instead
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset || reset_hold)
			cmd_reset <= 1'b1;
		else if (i_cpu.brk && !START_HALTED)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= i_cmd.fire && i_cmd.strb[0] && i_cmd_word.cmd.reset;
	end

	//////////////////////////////
	// Halt
	//////////////////////////////

	// Later assignments win, so halting reasons come after the release
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_halt <= START_HALTED;
		else if (i_cpu_reset && !i_cmd.valid && !wr_stall)
			cmd_halt <= START_HALTED;
		else if (cmd_reset && START_HALTED)
			cmd_halt <= START_HALTED;
		else
		begin
			// Release by step, or by a write without halt
			if (!i_wr_pending && !i_cpu.stall && cmd_b1
					&& (!i_cmd_word.cmd.halt || i_cmd_word.cmd.step))
				cmd_halt <= 1'b0;
			if (i_cpu.brk && START_HALTED)
				cmd_halt <= 1'b1;
			// Explicit halt request, not a step
			if (cmd_b1 && i_cmd_word.cmd.halt && !i_cmd_word.cmd.step)
				cmd_halt <= 1'b1;
			// Register writes need a stopped CPU
			if (i_reg_unhalt)
				cmd_halt <= 1'b1;
			// Stop again once a step or cache clear was taken
			if (cmd_step || cmd_clear_cache)
				cmd_halt <= 1'b1;
			if (cmd_b1 && i_cmd_word.cmd.clear_cache)
				cmd_halt <= 1'b1;
		end
	end

	// Cache clear, only while halting
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (cmd_b1 && i_cmd_word.cmd.clear_cache && i_cmd_word.cmd.halt)
			cmd_clear_cache <= 1'b1;
		else if (cmd_halt && !i_cpu.stall)
			cmd_clear_cache <= 1'b0;
	end

	// Single step request
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (cmd_b1 && i_cmd_word.cmd.step)
			cmd_step <= 1'b1;
		else if (!i_cpu.stall)
			cmd_step <= 1'b0;
	end

	assign o_cpu_reset = cmd_reset;
	assign o_cpu_halt = cmd_halt;
	assign o_cpu_clear_cache = cmd_clear_cache;

	//////////////////////////////
	// Status word
	//////////////////////////////

	always_comb
	begin
		o_status = '0;
		o_status[16] = i_interrupt;
		o_status[14] = i_cpu.brk;
		o_status[13:11] = i_cpu.cc;
		o_status[HALT_BIT] = cmd_halt;
		// Set when the CPU is idle
		o_status[9] = !i_cpu.stall;
		o_status[7] = i_interrupt;
		o_status[RESET_BIT] = cmd_reset;
	end

endmodule

//--- design/zip_dbg_top.sv
// Debug controller top level
// AXI-lite debug slave for a small RISC CPU, skid buffers feeding the
// write and read stages, and run control for the CPU
`timescale 1ns/1ps

module zip_dbg_top import zip_dbg_pkg::*; #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED = 1'b0
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// Debug bus, write side
	input  logic                    S_DBG_AWVALID,
	output logic                    S_DBG_AWREADY,
	input  logic [DBG_ADDR_W-1:0]   S_DBG_AWADDR,
	input  logic [2:0]              S_DBG_AWPROT,
	input  logic                    S_DBG_WVALID,
	output logic                    S_DBG_WREADY,
	input  dbg_word_t               S_DBG_WDATA,
	input  logic [DBG_DATA_W/8-1:0] S_DBG_WSTRB,
	output logic                    S_DBG_BVALID,
	input  logic                    S_DBG_BREADY,
	output logic [1:0]              S_DBG_BRESP,
	// Debug bus, read side
	input  logic                    S_DBG_ARVALID,
	output logic                    S_DBG_ARREADY,
	input  logic [DBG_ADDR_W-1:0]   S_DBG_ARADDR,
	input  logic [2:0]              S_DBG_ARPROT,
	output logic                    S_DBG_RVALID,
	input  logic                    S_DBG_RREADY,
	output dbg_word_t               S_DBG_RDATA,
	output logic [1:0]              S_DBG_RRESP,
	// CPU side
	input  logic                    i_cpu_reset,
	input  logic                    i_interrupt,
	input  cpu_dbg_t                i_cpu,
	input  dbg_word_t               i_dbg_rdata,
	output dbg_wr_t                 o_dbg_wr,
	output dbg_reg_t                o_dbg_rreg,
	output logic                    o_cpu_reset,
	output logic                    o_cpu_halt,
	output logic                    o_cpu_clear_cache,
	output logic                    o_halted
);

	localparam int WSKD_W = DBG_DATA_W + DBG_DATA_W/8;

	logic aw_valid, w_valid, ar_valid, wr_ready, ar_ready, reg_unhalt;
	dbg_waddr_t aw_addr, ar_addr;
	logic [WSKD_W-1:0] w_skd;
	dbg_cmd_req_t cmd;
	dbg_wdata_u cmd_word;
	dbg_word_t status;

	dbg_skid #(.DW(DBG_ADDR_W-DBG_LSB)) u_aw_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(S_DBG_AWVALID), .o_ready(S_DBG_AWREADY),
		.i_data(S_DBG_AWADDR[DBG_ADDR_W-1:DBG_LSB]),
		.o_valid(aw_valid), .i_ready(wr_ready), .o_data(aw_addr)
	);

	// W carries data and strobes together
	dbg_skid #(.DW(WSKD_W)) u_w_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(S_DBG_WVALID), .o_ready(S_DBG_WREADY),
		.i_data({S_DBG_WDATA, S_DBG_WSTRB}),
		.o_valid(w_valid), .i_ready(wr_ready), .o_data(w_skd)
	);

	dbg_skid #(.DW(DBG_ADDR_W-DBG_LSB)) u_ar_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(S_DBG_ARVALID), .o_ready(S_DBG_ARREADY),
		.i_data(S_DBG_ARADDR[DBG_ADDR_W-1:DBG_LSB]),
		.o_valid(ar_valid), .i_ready(ar_ready), .o_data(ar_addr)
	);

	dbg_write_stage u_write (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_aw_valid(aw_valid), .i_aw_addr(aw_addr),
		.i_w_valid(w_valid), .i_w_data(w_skd[WSKD_W-1:DBG_DATA_W/8]),
		.i_w_strb(w_skd[DBG_DATA_W/8-1:0]), .o_wr_ready(wr_ready),
		.i_cpu_stall(i_cpu.stall), .o_dbg_wr,
		.o_cmd(cmd), .o_cmd_word(cmd_word), .o_reg_unhalt(reg_unhalt),
		.S_DBG_BVALID, .i_bready(S_DBG_BREADY), .S_DBG_BRESP
	);

	dbg_read_stage u_read (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_ar_valid(ar_valid), .i_ar_addr(ar_addr), .o_ar_ready(ar_ready),
		.o_dbg_rreg, .i_dbg_rdata, .i_status(status),
		.S_DBG_RVALID, .i_rready(S_DBG_RREADY), .S_DBG_RDATA, .S_DBG_RRESP
	);

	cpu_run_ctrl #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) u_run_ctrl (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_cpu_reset, .i_interrupt,
		.i_cmd(cmd), .i_cmd_word(cmd_word), .i_reg_unhalt(reg_unhalt),
		.i_cpu, .i_wr_pending(o_dbg_wr.we),
		.o_cpu_reset, .o_cpu_halt, .o_cpu_clear_cache, .o_status(status)
	);

	// CPU idle
	assign o_halted = !i_cpu.stall;

endmodule

//--- verif/zip_dbg_sva.sv
// Debug bus handshake checks
// Bound onto the debug controller top level
`timescale 1ns/1ps

module zip_dbg_sva (
	input logic        S_AXI_ACLK,
	input logic        S_AXI_ARESETN,
	input logic        S_DBG_BVALID,
	input logic        S_DBG_BREADY,
	input logic [1:0]  S_DBG_BRESP,
	input logic        S_DBG_RVALID,
	input logic        S_DBG_RREADY,
	input logic [31:0] S_DBG_RDATA,
	input logic [1:0]  S_DBG_RRESP
);

	// R and B stay put while stalled by the master
	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_DBG_RVALID && !S_DBG_RREADY |=> S_DBG_RVALID && $stable(S_DBG_RDATA))
		else $error("R not held under back-pressure");
	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_DBG_BVALID && !S_DBG_BREADY |=> S_DBG_BVALID && $stable(S_DBG_BRESP))
		else $error("B not held under back-pressure");

	// Always OKAY
	resp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_DBG_RRESP == 2'b00 && S_DBG_BRESP == 2'b00)
		else $error("Response code not OKAY");

	// Quiet bus after reset
	reset_idle: assert property (@(posedge S_AXI_ACLK)
		!S_AXI_ARESETN |=> !S_DBG_RVALID && !S_DBG_BVALID)
		else $error("Valid high after reset");

endmodule

bind zip_dbg_top zip_dbg_sva u_sva (
	.S_AXI_ACLK, .S_AXI_ARESETN,
	.S_DBG_BVALID, .S_DBG_BREADY, .S_DBG_BRESP,
	.S_DBG_RVALID, .S_DBG_RREADY, .S_DBG_RDATA, .S_DBG_RRESP
);

//--- verif/tb_zip_dbg.sv
// Debug controller testbench
// Random AXI-lite traffic, a CPU model with register file and stall,
// and a reference model for status, registers and run control
`timescale 1ns/1ps

module tb_zip_dbg import zip_dbg_pkg::*; ;

	localparam int RESET_DURATION = 10;
	localparam bit START_HALTED = 1'b0;
	localparam int N_RAND = 300;
	localparam int TIMEOUT = 400 * 12;

	logic S_AXI_ACLK = 1'b0, S_AXI_ARESETN;
	logic S_DBG_AWVALID, S_DBG_AWREADY, S_DBG_WVALID, S_DBG_WREADY;
	logic S_DBG_BVALID, S_DBG_BREADY, S_DBG_ARVALID, S_DBG_ARREADY;
	logic S_DBG_RVALID, S_DBG_RREADY;
	logic [7:0] S_DBG_AWADDR, S_DBG_ARADDR;
	logic [2:0] S_DBG_AWPROT, S_DBG_ARPROT;
	logic [3:0] S_DBG_WSTRB;
	logic [1:0] S_DBG_BRESP, S_DBG_RRESP;
	dbg_word_t S_DBG_WDATA, S_DBG_RDATA, i_dbg_rdata;
	logic i_cpu_reset, i_interrupt, o_cpu_reset, o_cpu_halt, o_cpu_clear_cache, o_halted;
	cpu_dbg_t i_cpu;
	dbg_wr_t o_dbg_wr;
	dbg_reg_t o_dbg_rreg;

	// CPU model state
	logic cpu_stall = 1'b0, cpu_brk, wr_busy = 1'b0;
	logic [2:0] cpu_cc;
	int stall_left = 0;
	dbg_word_t cpu_regs [32];
	// Reference model
	dbg_word_t ref_regs [32];
	dbg_wr_t exp_wr_q [$];
	logic exp_halt;
	int b_seen = 0, b_exp = 0, r_seen = 0, r_exp = 0, cc_cycles = 0, rst_cycles = 0;
	int cycles = 0;

	zip_dbg_top #(.RESET_DURATION(RESET_DURATION), .START_HALTED(START_HALTED))
		u_zip_dbg_top (.*);

	assign i_cpu = '{stall: cpu_stall, brk: cpu_brk, cc: cpu_cc};
	// Register file lookup, combinational
	assign i_dbg_rdata = cpu_regs[o_dbg_rreg];

	always #10 S_AXI_ACLK = ~S_AXI_ACLK;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input dbg_word_t got, input dbg_word_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_wr(input dbg_wr_t got, input dbg_wr_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error: o_dbg_wr got %h expected %h", got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	// Status field map
	function automatic dbg_word_t exp_status(input logic intr, input logic brk,
			input logic [2:0] cc, input logic stall, input logic halt, input logic rst);
		dbg_word_t s;
		s = '0;
		s[16] = intr;
		s[14] = brk;
		s[13:11] = cc;
		s[10] = halt;
		s[9] = !stall;
		s[7] = intr;
		s[6] = rst;
		return s;
	endfunction

	//////////////////////////////
	// Monitors
	//////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
			fail_run("Timeout, the run went past its cycle limit");
	end

	// Mid-cycle sampling, handshakes and pulses
	always @(negedge S_AXI_ACLK)
	begin
		if (S_DBG_BVALID && S_DBG_BREADY)
			b_seen++;
		if (S_DBG_RVALID && S_DBG_RREADY)
			r_seen++;
		if (o_cpu_clear_cache)
			cc_cycles++;
		if (o_cpu_reset)
			rst_cycles++;
		// Idle flag follows the CPU stall
		check_bit("o_halted", o_halted, !cpu_stall);
	end

	// CPU model, takes each write once and stalls 0 to 3 cycles
	always @(posedge S_AXI_ACLK)
	begin
		#1;
		if (o_dbg_wr.we && !wr_busy)
		begin
			if (exp_wr_q.size() == 0)
				fail_run("Register write pulse with no write outstanding");
			check_wr(o_dbg_wr, exp_wr_q.pop_front());
			cpu_regs[o_dbg_wr.wreg] = o_dbg_wr.data;
			stall_left = $urandom % 4;
			wr_busy = 1'b1;
		end
		if (stall_left > 0)
		begin
			cpu_stall = 1'b1;
			stall_left--;
		end
		else
		begin
			cpu_stall = 1'b0;
			wr_busy = 1'b0;
		end
	end

	//////////////////////////////
	// Bus tasks
	//////////////////////////////

	task automatic wait_idle;
		do
		begin
			@(posedge S_AXI_ACLK);
			#2;
		end while (o_dbg_wr.we || cpu_stall);
	endtask

	task automatic axi_write(input logic [7:0] addr, input dbg_word_t data, input logic [3:0] strb);
		logic aw_done, w_done, b_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		b_done = 1'b0;
		@(posedge S_AXI_ACLK);
		#1;
		S_DBG_AWVALID = 1'b1;
		S_DBG_AWADDR = addr;
		S_DBG_WVALID = 1'b1;
		S_DBG_WDATA = data;
		S_DBG_WSTRB = strb;
		while (!(aw_done && w_done))
		begin
			if (S_DBG_AWVALID && S_DBG_AWREADY)
				aw_done = 1'b1;
			if (S_DBG_WVALID && S_DBG_WREADY)
				w_done = 1'b1;
			@(posedge S_AXI_ACLK);
			#1;
			S_DBG_AWVALID = S_DBG_AWVALID && !aw_done;
			S_DBG_WVALID = S_DBG_WVALID && !w_done;
		end
		b_exp++;
		// Random back-pressure on B
		while (!b_done)
		begin
			S_DBG_BREADY = 1'($urandom % 2);
			b_done = S_DBG_BVALID && S_DBG_BREADY;
			@(posedge S_AXI_ACLK);
			#1;
		end
		S_DBG_BREADY = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output dbg_word_t data);
		logic r_done;
		r_done = 1'b0;
		@(posedge S_AXI_ACLK);
		#1;
		S_DBG_ARVALID = 1'b1;
		S_DBG_ARADDR = addr;
		while (S_DBG_ARVALID)
		begin
			r_done = S_DBG_ARREADY;
			@(posedge S_AXI_ACLK);
			#1;
			S_DBG_ARVALID = !r_done;
		end
		r_exp++;
		r_done = 1'b0;
		while (!r_done)
		begin
			S_DBG_RREADY = 1'($urandom % 2);
			r_done = S_DBG_RVALID && S_DBG_RREADY;
			data = S_DBG_RDATA;
			@(posedge S_AXI_ACLK);
			#1;
		end
		S_DBG_RREADY = 1'b0;
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic reg_write(input dbg_reg_t idx, input dbg_word_t data, input logic [3:0] strb);
		// Zero strobe gives only a B response
		if (strb != 4'b0)
		begin
			ref_regs[idx] = data;
			exp_wr_q.push_back('{we: 1'b1, wreg: idx, data: data});
			exp_halt = 1'b1;
		end
		axi_write({1'b0, idx, 2'b00}, data, strb);
		check_bit("o_cpu_halt", o_cpu_halt, exp_halt);
	endtask

	task automatic reg_read(input dbg_reg_t idx);
		dbg_word_t got;
		axi_read({1'b1, idx, 2'b00}, got);
		check_word("S_DBG_RDATA", got, ref_regs[idx]);
	endtask

	task automatic cmd_write(input dbg_word_t data, input logic [3:0] strb);
		wait_idle();
		axi_write(8'h80, data, strb);
	endtask

	task automatic status_test;
		dbg_word_t got;
		wait_idle();
		@(posedge S_AXI_ACLK);
		#1;
		cpu_brk = 1'($urandom);
		cpu_cc = 3'($urandom);
		i_interrupt = 1'($urandom);
		// Break reaches the reset bit one cycle later
		repeat (2) @(posedge S_AXI_ACLK);
		axi_read({1'b0, 5'($urandom), 2'b00}, got);
		check_word("S_DBG_RDATA", got,
				exp_status(i_interrupt, cpu_brk, cpu_cc, cpu_stall, exp_halt, cpu_brk));
		cpu_brk = 1'b0;
		repeat (2) @(posedge S_AXI_ACLK);
	endtask

	initial
	begin
		int n, c0, kind;
		void'($urandom(52383));
		{S_DBG_AWVALID, S_DBG_WVALID, S_DBG_BREADY, S_DBG_ARVALID, S_DBG_RREADY} = '0;
		{S_DBG_AWADDR, S_DBG_ARADDR, S_DBG_AWPROT, S_DBG_ARPROT} = '0;
		S_DBG_WDATA = '0;
		S_DBG_WSTRB = '0;
		{i_cpu_reset, i_interrupt, cpu_brk} = '0;
		cpu_cc = '0;
		exp_halt = START_HALTED;
		for (int i = 0; i < 32; i++)
		begin
			cpu_regs[i] = (dbg_word_t'(i) * 32'h01000193) ^ 32'h9e3779b9;
			ref_regs[i] = cpu_regs[i];
		end
		S_AXI_ARESETN = 1'b0;
		repeat (10) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// Reset hold length after release
		check_bit("o_cpu_reset", o_cpu_reset, 1'b1);
		n = 0;
		while (o_cpu_reset && n < 50)
		begin
			@(posedge S_AXI_ACLK);
			#1;
			n++;
		end
		if (n != RESET_DURATION + 1)
			fail_run("o_cpu_reset was held for the wrong number of cycles after reset");
		check_bit("o_cpu_halt", o_cpu_halt, START_HALTED);
		status_test();

		// Halt, release, step
		cmd_write(32'd1 << HALT_BIT, 4'b0010);
		exp_halt = 1'b1;
		check_bit("o_cpu_halt", o_cpu_halt, exp_halt);
		cmd_write(32'd0, 4'b0010);
		exp_halt = 1'b0;
		check_bit("o_cpu_halt", o_cpu_halt, exp_halt);
		cmd_write(32'd1 << STEP_BIT, 4'b0010);
		exp_halt = 1'b1;
		check_bit("o_cpu_halt", o_cpu_halt, exp_halt);

		// Cache clear while halted
		c0 = cc_cycles;
		cmd_write((32'd1 << CLEAR_CACHE_BIT) | (32'd1 << HALT_BIT), 4'b0010);
		repeat (2) @(posedge S_AXI_ACLK);
		if (cc_cycles - c0 != 1)
			fail_run("o_cpu_clear_cache did not pulse for exactly one cycle");
		check_bit("o_cpu_halt", o_cpu_halt, exp_halt);

		// Reset command
		c0 = rst_cycles;
		cmd_write(32'd1 << RESET_BIT, 4'b0001);
		repeat (2) @(posedge S_AXI_ACLK);
		if (rst_cycles - c0 != 1)
			fail_run("o_cpu_reset did not pulse for exactly one cycle");

		// Running CPU, a register write must halt it
		cmd_write(32'd0, 4'b0010);
		exp_halt = 1'b0;
		check_bit("o_cpu_halt", o_cpu_halt, exp_halt);
		reg_write(5'd3, 32'hdeadbeef, 4'b0000);
		reg_write(5'd7, 32'h12345678, 4'b1111);
		reg_read(5'd3);
		reg_read(5'd7);

		// Random mix with back-pressure
		for (int t = 0; t < N_RAND; t++)
		begin
			kind = $urandom % 3;
			if (kind == 0)
				reg_write(5'($urandom), $urandom, 4'($urandom));
			else if (kind == 1)
				reg_read(5'($urandom));
			else
				status_test();
		end

		wait_idle();
		repeat (2) @(posedge S_AXI_ACLK);
		// No response left over
		check_bit("S_DBG_BVALID", S_DBG_BVALID, 1'b0);
		check_bit("S_DBG_RVALID", S_DBG_RVALID, 1'b0);
		if (b_seen != b_exp || r_seen != r_exp)
			fail_run("Response count differs from accepted address count");
		else if (exp_wr_q.size() != 0)
			fail_run("Register write never reached the CPU");
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

//--- filelist.f
common/zip_dbg_pkg.sv
design/dbg_skid.sv
debug_port/dbg_write_stage.sv
debug_port/dbg_read_stage.sv
design/cpu_run_ctrl.sv
design/zip_dbg_top.sv
verif/zip_dbg_sva.sv
verif/tb_zip_dbg.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = tb_zip_dbg
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
